// File: common/fetch_pkg.sv
package fetch_pkg;

    // address and instruction width
    localparam int xlen = 32;

    // one cache line holds eight instructions
    localparam int line_bits      = 256;
    localparam int words_per_line = line_bits / xlen;
    localparam int offset_bits    = 5;

    // burst memory moves 64 bits per beat
    localparam int beat_bits      = 64;
    localparam int beats_per_line = line_bits / beat_bits;
    localparam int beat_idx_bits  = $clog2(beats_per_line);

    localparam int order_bits = 64;

    // instruction queue
    localparam int queue_depth    = 32;
    localparam int queue_ptr_bits = $clog2(queue_depth);
    localparam int queue_cnt_bits = queue_ptr_bits + 1;

    localparam logic [xlen-1:0] reset_pc = 32'haaaaa000;

    // one queued instruction, order in the top bits
    typedef struct packed {
        logic [order_bits-1:0] order;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       inst;
    } fetch_entry_t;

endpackage : fetch_pkg

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module fetch_tb -f tb.f -o fetch_sim > build.log 2>&1 \
    && ./obj_dir/fetch_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation reported failure"; exit 1; } \
    || echo "simulation finished without failure"

// File: tb.f
common/fetch_pkg.sv
verilog/line_refill.sv
verilog/line_buffer.sv
verilog/fetch_queue.sv
verilog/fetch_ctrl.sv
verilog/fetch_unit.sv
testbench/tb_clock.sv
testbench/fetch_tb.sv

// File: testbench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    // pops issued over all tests, sets the cycle limit
    localparam int total_pops  = 220;
    localparam int cycle_limit = 40 * total_pops + 2000;

    logic                             clk;
    logic                             rst;
    logic                             redirect_i;
    logic [fetch_pkg::xlen-1:0]       redirect_pc_i;
    logic                             deq_i;
    logic [fetch_pkg::xlen-1:0]       bmem_addr_o;
    logic                             bmem_read_o;
    logic                             bmem_ready_i = 1'b0;
    logic [fetch_pkg::xlen-1:0]       bmem_raddr_i = '0;
    logic [fetch_pkg::beat_bits-1:0]  bmem_rdata_i = '0;
    logic                             bmem_rvalid_i = 1'b0;
    logic                             inst_valid_o;
    logic [fetch_pkg::xlen-1:0]       inst_pc_o;
    logic [fetch_pkg::xlen-1:0]       inst_o;
    logic [fetch_pkg::order_bits-1:0] inst_order_o;

    int    check_errors = 0;
    int    proto_errors = 0;
    int    stim_errors = 0;
    int    pops = 0;
    int    cycles = 0;
    string test_name = "reset_seq";

    // reference model state
    logic [fetch_pkg::xlen-1:0]       exp_pc = fetch_pkg::reset_pc;
    logic [fetch_pkg::order_bits-1:0] last_order = '0;
    logic                             first_pop = 1'b1;
    logic                             after_redirect = 1'b0;

    // memory model state
    int                         req_count = 0;
    int                         served_count = 0;
    logic [fetch_pkg::xlen-1:0] req_addr = '0;
    logic [fetch_pkg::xlen-1:0] beat_addr;
    logic [fetch_pkg::xlen-1:0] rand_addr;

    tb_clock clk_gen (.clk_o(clk));

    fetch_unit fetch_unit_i (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .deq_i         (deq_i),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .inst_valid_o  (inst_valid_o),
        .inst_pc_o     (inst_pc_o),
        .inst_o        (inst_o),
        .inst_order_o  (inst_order_o)
    );

    // instruction word stored at byte address a
    function automatic logic [31:0] inst_word(input logic [31:0] a);
        return (a ^ {a[15:0], a[31:16]}) * 32'h9e37_79b1 + 32'h0000_0013;
    endfunction

    // memory side: request monitor
    always @(posedge clk) begin
        if (!rst && bmem_read_o) begin
            if (req_count != served_count) begin
                proto_errors++;
                $display("memory got a read while another read was still outstanding");
            end
            if (!bmem_ready_i) begin
                proto_errors++;
                $display("memory got a read while bmem_ready_i was low");
            end
            if (bmem_addr_o[fetch_pkg::offset_bits-1:0] != '0) begin
                proto_errors++;
                $display("** Error [%s] read address offset: expected 00, actual %h",
                         test_name, bmem_addr_o[fetch_pkg::offset_bits-1:0]);
            end
            req_addr = bmem_addr_o;
            req_count++;
        end
    end

    always @(negedge clk) begin
        bmem_ready_i = ($urandom_range(3) != 0);
    end

    // beat k holds words 2k and 2k+1
    always begin
        @(negedge clk);
        if (served_count != req_count) begin
            repeat ($urandom_range(5, 1)) @(negedge clk);
            beat_addr = req_addr;
            for (int k = 0; k < fetch_pkg::beats_per_line; k++) begin
                if (k > 0) begin
                    repeat ($urandom_range(2)) @(negedge clk);
                end
                bmem_raddr_i  = req_addr;
                bmem_rdata_i  = {inst_word(beat_addr + 32'd4), inst_word(beat_addr)};
                bmem_rvalid_i = 1'b1;
                @(negedge clk);
                bmem_rvalid_i = 1'b0;
                beat_addr     = beat_addr + 32'd8;
            end
            served_count++;
        end
    end

    // compare every pop against the reference model
    always @(posedge clk) begin
        if (!rst && redirect_i) begin
            exp_pc         = redirect_pc_i;
            after_redirect = 1'b1;
        end else if (!rst && deq_i) begin
            pops++;
            if (inst_pc_o != exp_pc) begin
                check_errors++;
                $display("** Error [%s] pc: expected %h, actual %h", test_name, exp_pc, inst_pc_o);
            end
            if (inst_o != inst_word(exp_pc)) begin
                check_errors++;
                $display("** Error [%s] inst at %h: expected %h, actual %h",
                         test_name, exp_pc, inst_word(exp_pc), inst_o);
            end
            if (first_pop && inst_order_o != '0) begin
                check_errors++;
                $display("** Error [%s] order: expected 0, actual %0d", test_name, inst_order_o);
            end
            if (!first_pop && after_redirect && inst_order_o <= last_order) begin
                check_errors++;
                $display("** Error [%s] order: expected > %0d, actual %0d",
                         test_name, last_order, inst_order_o);
            end
            if (!first_pop && !after_redirect && inst_order_o != last_order + 64'd1) begin
                check_errors++;
                $display("** Error [%s] order: expected %0d, actual %0d",
                         test_name, last_order + 64'd1, inst_order_o);
            end
            exp_pc         = exp_pc + 32'd4;
            last_order     = inst_order_o;
            first_pop      = 1'b0;
            after_redirect = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d pops done", cycles, pops);
            $display("Some tests failed");
            $finish;
        end
    end

    // pop n entries, idle up to max_gap cycles before each
    task automatic pop_some(input int n, input int max_gap);
        int gap;
        for (int k = 0; k < n; k++) begin
            gap = (max_gap > 0) ? int'($urandom_range(max_gap)) : 0;
            repeat (gap) @(negedge clk);
            while (!inst_valid_o) @(negedge clk);
            deq_i = 1'b1;
            @(negedge clk);
            deq_i = 1'b0;
        end
    endtask

    task automatic redirect_to(input logic [31:0] addr);
        redirect_pc_i = addr;
        redirect_i    = 1'b1;
        @(negedge clk);
        redirect_i = 1'b0;
        if (inst_valid_o) begin
            stim_errors++;
            $display("** Error [%s] inst_valid_o after redirect: expected 0, actual 1", test_name);
        end
    endtask

    initial begin
        void'($urandom(53642));
        rst           = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        deq_i         = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        pop_some(41, 0);

        // long stalls let the queue fill up
        test_name = "backpressure";
        pop_some(20, 3);
        repeat (150) @(negedge clk);
        pop_some(40, 2);
        repeat (150) @(negedge clk);
        pop_some(20, 0);

        test_name = "redirect";
        repeat (3) begin
            pop_some(5, 1);
            while (!inst_valid_o) @(negedge clk);
            redirect_to($urandom & 32'hffff_fffc);
            pop_some(12, 1);
        end

        test_name = "redirect_same_line";
        repeat (2) begin
            rand_addr = $urandom & 32'hffff_ffe0;
            redirect_to(rand_addr);
            while (!inst_valid_o) @(negedge clk);
            redirect_to(rand_addr | ($urandom_range(7) << 2));
            pop_some(12, 0);
        end

        test_name = "redirect_in_flight";
        repeat (2) begin
            redirect_to($urandom & 32'hffff_fffc);
            while (served_count == req_count) @(negedge clk);
            redirect_to($urandom & 32'hffff_fffc);
            pop_some(12, 1);
        end

        repeat (4) @(negedge clk);
        $display("pops %0d, check errors %0d, protocol errors %0d, stimulus errors %0d",
                 pops, check_errors, proto_errors, stim_errors);
        if (check_errors == 0 && proto_errors == 0 && stim_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : fetch_tb

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

endmodule : tb_clock

// File: verilog/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        redirect_i,
    input  logic [fetch_pkg::xlen-1:0]  redirect_pc_i,

    input  logic                        hit_i,
    input  logic [fetch_pkg::xlen-1:0]  word_i,
    input  logic                        refill_done_i,
    input  logic                        queue_full_i,

    output logic [fetch_pkg::xlen-1:0]  pc_o,
    output logic                        refill_req_o,
    output logic [fetch_pkg::xlen-1:0]  refill_addr_o,
    output logic                        enq_o,
    output fetch_pkg::fetch_entry_t     enq_entry_o
);

    logic [fetch_pkg::xlen-1:0]        pc_q;
    logic [fetch_pkg::order_bits-1:0]  order_q;
    logic                              pending_q;
    logic                              refill_req_q;
    logic [fetch_pkg::xlen-1:0]        refill_addr_q;
    logic                              miss_req;

    // a redirect cycle neither fetches nor requests
    assign miss_req = !hit_i && !pending_q && !redirect_i;
    assign enq_o    = hit_i && !queue_full_i && !redirect_i;

    assign enq_entry_o = '{
        order: order_q,
        pc:    pc_q,
        inst:  word_i
    };

    assign pc_o          = pc_q;
    assign refill_req_o  = refill_req_q;
    assign refill_addr_o = refill_addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q         <= fetch_pkg::reset_pc;
            order_q      <= '0;
            pending_q    <= 1'b0;
            refill_req_q <= 1'b0;
        end else begin
            refill_req_q <= miss_req;

            // in-flight refill still finishes after a redirect
            if (miss_req) begin
                pending_q <= 1'b1;
            end else if (refill_done_i) begin
                pending_q <= 1'b0;
            end

            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (enq_o) begin
                pc_q    <= pc_q + 32'd4;
                order_q <= order_q + 1'b1;
            end
        end
    end

    // line-aligned request address
    always_ff @(posedge clk) begin
        if (miss_req) begin
            refill_addr_q <= {pc_q[fetch_pkg::xlen-1:fetch_pkg::offset_bits],
                              {fetch_pkg::offset_bits{1'b0}}};
        end
    end

    a_redirect_aligned: assert property (@(posedge clk) disable iff (rst)
        redirect_i |-> redirect_pc_i[1:0] == 2'b00);

endmodule : fetch_ctrl

// File: verilog/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   flush_i,

    input  logic                   enq_i,
    input  fetch_pkg::fetch_entry_t entry_i,

    input  logic                   deq_i,
    output fetch_pkg::fetch_entry_t entry_o,

    output logic                   full_o,
    output logic                   empty_o
);

    fetch_pkg::fetch_entry_t                 mem [fetch_pkg::queue_depth];
    logic [fetch_pkg::queue_ptr_bits-1:0]    wr_ptr_q;
    logic [fetch_pkg::queue_ptr_bits-1:0]    rd_ptr_q;
    logic [fetch_pkg::queue_cnt_bits-1:0]    count_q;
    logic                                    do_enq;
    logic                                    do_deq;

    // depth is a power of two, so the count msb means full
    assign full_o  = count_q[fetch_pkg::queue_ptr_bits];
    assign empty_o = (count_q == '0);

    assign do_enq = enq_i && (!full_o || deq_i);
    assign do_deq = deq_i && !empty_o;

    assign entry_o = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_deq) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (do_enq && !do_deq) begin
                count_q <= count_q + 1'b1;
            end else if (do_deq && !do_enq) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr_q] <= entry_i;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (enq_i && full_o) |-> deq_i);

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        deq_i |-> !empty_o);

endmodule : fetch_queue

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             redirect_i,
    input  logic [fetch_pkg::xlen-1:0]       redirect_pc_i,
    input  logic                             deq_i,

    output logic [fetch_pkg::xlen-1:0]       bmem_addr_o,
    output logic                             bmem_read_o,
    input  logic                             bmem_ready_i,
    input  logic [fetch_pkg::xlen-1:0]       bmem_raddr_i,
    input  logic [fetch_pkg::beat_bits-1:0]  bmem_rdata_i,
    input  logic                             bmem_rvalid_i,

    output logic                             inst_valid_o,
    output logic [fetch_pkg::xlen-1:0]       inst_pc_o,
    output logic [fetch_pkg::xlen-1:0]       inst_o,
    output logic [fetch_pkg::order_bits-1:0] inst_order_o
);

    logic                             refill_req;
    logic [fetch_pkg::xlen-1:0]       refill_addr;
    logic                             refill_done;
    logic [fetch_pkg::line_bits-1:0]  refill_line;
    logic [fetch_pkg::xlen-1:0]       refill_tag;
    logic [fetch_pkg::xlen-1:0]       pc;
    logic                             hit;
    logic [fetch_pkg::xlen-1:0]       hit_word;
    logic                             enq;
    fetch_pkg::fetch_entry_t          enq_entry;
    fetch_pkg::fetch_entry_t          head_entry;
    logic                             queue_full;
    logic                             queue_empty;

    line_refill line_refill_i (
        .clk           (clk),
        .rst           (rst),
        .refill_req_i  (refill_req),
        .refill_addr_i (refill_addr),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .refill_done_o (refill_done),
        .refill_line_o (refill_line),
        .refill_tag_o  (refill_tag)
    );

    line_buffer line_buffer_i (
        .clk    (clk),
        .rst    (rst),
        .load_i (refill_done),
        .line_i (refill_line),
        .tag_i  (refill_tag),
        .pc_i   (pc),
        .hit_o  (hit),
        .word_o (hit_word)
    );

    fetch_ctrl fetch_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .hit_i         (hit),
        .word_i        (hit_word),
        .refill_done_i (refill_done),
        .queue_full_i  (queue_full),
        .pc_o          (pc),
        .refill_req_o  (refill_req),
        .refill_addr_o (refill_addr),
        .enq_o         (enq),
        .enq_entry_o   (enq_entry)
    );

    fetch_queue fetch_queue_i (
        .clk     (clk),
        .rst     (rst),
        .flush_i (redirect_i),
        .enq_i   (enq),
        .entry_i (enq_entry),
        .deq_i   (deq_i),
        .entry_o (head_entry),
        .full_o  (queue_full),
        .empty_o (queue_empty)
    );

    // head of the queue
    assign inst_valid_o = !queue_empty;
    assign inst_pc_o    = head_entry.pc;
    assign inst_o       = head_entry.inst;
    assign inst_order_o = head_entry.order;

endmodule : fetch_unit

// File: verilog/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            load_i,
    input  logic [fetch_pkg::line_bits-1:0] line_i,
    input  logic [fetch_pkg::xlen-1:0]      tag_i,

    input  logic [fetch_pkg::xlen-1:0]      pc_i,
    output logic                            hit_o,
    output logic [fetch_pkg::xlen-1:0]      word_o
);

    logic                                                       valid_q;
    logic [fetch_pkg::xlen-fetch_pkg::offset_bits-1:0]          tag_q;
    logic [fetch_pkg::words_per_line-1:0][fetch_pkg::xlen-1:0]  line_q;
    logic [fetch_pkg::offset_bits-3:0]                          word_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end
    end

    // tag keeps only the line address
    always_ff @(posedge clk) begin
        if (load_i) begin
            tag_q  <= tag_i[fetch_pkg::xlen-1:fetch_pkg::offset_bits];
            line_q <= line_i;
        end
    end

    assign word_idx = pc_i[fetch_pkg::offset_bits-1:2];

    assign hit_o  = valid_q && (tag_q == pc_i[fetch_pkg::xlen-1:fetch_pkg::offset_bits]);
    assign word_o = line_q[word_idx];

endmodule : line_buffer

// File: verilog/line_refill.sv
`timescale 1ns/1ps

module line_refill (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           refill_req_i,
    input  logic [fetch_pkg::xlen-1:0]     refill_addr_i,

    input  logic                           bmem_ready_i,
    input  logic [fetch_pkg::xlen-1:0]     bmem_raddr_i,
    input  logic [fetch_pkg::beat_bits-1:0] bmem_rdata_i,
    input  logic                           bmem_rvalid_i,
    output logic [fetch_pkg::xlen-1:0]     bmem_addr_o,
    output logic                           bmem_read_o,

    output logic                           refill_done_o,
    output logic [fetch_pkg::line_bits-1:0] refill_line_o,
    output logic [fetch_pkg::xlen-1:0]     refill_tag_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_collect
    } state_t;

    state_t                                  state_q;
    logic [fetch_pkg::beat_idx_bits-1:0]     beat_cnt_q;
    logic                                    done_q;
    logic [fetch_pkg::xlen-1:0]              addr_q;
    logic [fetch_pkg::beats_per_line-1:0][fetch_pkg::beat_bits-1:0] line_q;
    logic                                    beat_ok;

    // only beats that answer our own request
    assign beat_ok = (state_q == st_collect) && bmem_rvalid_i && (bmem_raddr_i == addr_q);

    assign bmem_read_o   = (state_q == st_request) && bmem_ready_i;
    assign bmem_addr_o   = addr_q;
    assign refill_done_o = done_q;
    assign refill_line_o = line_q;
    assign refill_tag_o  = addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= st_idle;
            beat_cnt_q <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (refill_req_i) begin
                        state_q <= st_request;
                    end
                end
                st_request: begin
                    if (bmem_ready_i) begin
                        state_q    <= st_collect;
                        beat_cnt_q <= '0;
                    end
                end
                st_collect: begin
                    if (beat_ok) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        // last beat of the line
                        if (&beat_cnt_q) begin
                            state_q <= st_idle;
                            done_q  <= 1'b1;
                        end
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && refill_req_i) begin
            addr_q <= refill_addr_i;
        end
        if (beat_ok) begin
            line_q[beat_cnt_q] <= bmem_rdata_i;
        end
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (rst)
        refill_req_i |-> state_q == st_idle);

    a_no_beat_idle: assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> state_q == st_collect);

endmodule : line_refill
